/* regex_pkg.sv */
//**************************************************************************
// Regex engine shared types: widths, opcodes, thread, instruction, window
//**************************************************************************
package regex_pkg;

  localparam int pc_width   = 6;
  localparam int cc_id_bits = 2;
  localparam int lanes      = 4;
  localparam int char_width = 8;

  // Instruction opcodes
  typedef enum logic [2:0] {
    op_match,
    op_any,
    op_jmp,
    op_split,
    op_accept
  } opcode_e;

  // One program word
  typedef struct packed {
    opcode_e               opcode;
    logic [char_width-1:0] ch;
    logic [pc_width-1:0]   target;
  } instr_t;

  // A thread is a pc plus the index of the char it looks at
  typedef struct packed {
    logic [pc_width-1:0]   pc;
    logic [cc_id_bits-1:0] cc_id;
  } thread_t;

  // Current input window, one char per lane
  typedef struct packed {
    logic [lanes-1:0][char_width-1:0] chars;
    logic [lanes-1:0]                 enable;
    logic [lanes-1:0]                 end_of_s;
  } window_t;

  // Run control states
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } run_state_e;

endpackage

/* instr_mem.sv */
//**************************************************************************
// Program memory, one write port and one registered read port per lane
//**************************************************************************
`timescale 1ns/1ps

module instr_mem (
  input  logic                                             clk,
  input  logic                                             wr_en,
  input  logic [regex_pkg::pc_width-1:0]                   wr_addr,
  input  regex_pkg::instr_t                                wr_instr,
  input  logic [regex_pkg::lanes-1:0][regex_pkg::pc_width-1:0] rd_pc,
  output regex_pkg::instr_t [regex_pkg::lanes-1:0]         rd_instr
);
  import regex_pkg::*;

  instr_t mem [2**pc_width];

  // Loaded only while the engine is idle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_instr;
    end
  end

  // Each core sees its word one cycle after presenting the pc
  always_ff @(posedge clk) begin
    for (int i = 0; i < lanes; i++) begin
      rd_instr[i] <= mem[rd_pc[i]];
    end
  end

endmodule

/* thread_fifo.sv */
//**************************************************************************
// Thread FIFO, circular buffer with first-word-fall-through read and flush
//**************************************************************************
`timescale 1ns/1ps

module thread_fifo #(
  parameter int fifo_depth_bits = 3
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               flush,
  input  logic               push,
  input  regex_pkg::thread_t din,
  output logic               full,
  input  logic               pop,
  output regex_pkg::thread_t dout,
  output logic               empty
);
  import regex_pkg::*;

  thread_t mem [2**fifo_depth_bits];

  logic [fifo_depth_bits-1:0] wr_ptr;
  logic [fifo_depth_bits-1:0] rd_ptr;
  logic [fifo_depth_bits:0]   count;
  logic                       do_push;
  logic                       do_pop;

  // Count reaches the depth only when its top bit is set
  assign full    = count[fifo_depth_bits];
  assign empty   = (count == '0);
  assign dout    = mem[rd_ptr];
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + do_push - do_pop;
    end
  end

endmodule

/* thread_arbiter.sv */
//**************************************************************************
// Two-input round-robin arbiter feeding one lane FIFO
//**************************************************************************
`timescale 1ns/1ps

module thread_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in0_valid,
  input  regex_pkg::thread_t in0_thread,
  output logic               in0_ready,
  input  logic               in1_valid,
  input  regex_pkg::thread_t in1_thread,
  output logic               in1_ready,
  output logic               out_valid,
  output regex_pkg::thread_t out_thread,
  input  logic               out_ready
);

  // Set means input 1 wins the next tie
  logic prio;
  logic grant0;
  logic grant1;

  assign grant0     = in0_valid && (!in1_valid || !prio);
  assign grant1     = in1_valid && (!in0_valid || prio);
  assign out_valid  = in0_valid || in1_valid;
  assign out_thread = grant1 ? in1_thread : in0_thread;
  assign in0_ready  = grant0 && out_ready;
  assign in1_ready  = grant1 && out_ready;

  // Hand the tie to the other side after each contested grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio <= 1'b0;
    end else if (in0_valid && in1_valid && out_ready) begin
      prio <= grant0;
    end
  end

endmodule

/* regex_core.sv */
//**************************************************************************
// Lane core, fetches and executes one thread at a time
//**************************************************************************
`timescale 1ns/1ps

module regex_core (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush,
  input  logic [regex_pkg::char_width-1:0] lane_char,
  input  logic                             lane_enable,
  input  logic                             lane_end,
  input  regex_pkg::thread_t               fifo_thread,
  input  logic                             fifo_empty,
  output logic                             pop,
  output logic [regex_pkg::pc_width-1:0]   fetch_pc,
  input  regex_pkg::instr_t                instr,
  output logic                             fwd_valid,
  output regex_pkg::thread_t               fwd_thread,
  input  logic                             fwd_ready,
  output logic                             loc_valid,
  output regex_pkg::thread_t               loc_thread,
  input  logic                             loc_ready,
  output logic                             accept_hit,
  output logic                             busy
);
  import regex_pkg::*;

  typedef enum logic [2:0] {
    cs_idle,
    cs_fetch,
    cs_exec,
    cs_split,
    cs_emit
  } core_state_e;

  core_state_e state;
  thread_t     thr;
  logic        char_ok;

  assign pop      = (state == cs_idle) && !fifo_empty && lane_enable;
  assign fetch_pc = thr.pc;
  assign busy     = (state != cs_idle);
  assign char_ok  = (instr.opcode == op_any) || (lane_char == instr.ch);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= cs_idle;
      thr        <= '0;
      fwd_valid  <= 1'b0;
      fwd_thread <= '0;
      loc_valid  <= 1'b0;
      loc_thread <= '0;
      accept_hit <= 1'b0;
    end else if (flush) begin
      state      <= cs_idle;
      fwd_valid  <= 1'b0;
      loc_valid  <= 1'b0;
      accept_hit <= 1'b0;
    end else begin
      accept_hit <= 1'b0;
      case (state)
        cs_idle: begin
          if (pop) begin
            thr   <= fifo_thread;
            state <= cs_fetch;
          end
        end
        // Memory read in flight
        cs_fetch: state <= cs_exec;
        cs_exec: begin
          state <= cs_idle;
          case (instr.opcode)
            op_match, op_any: begin
              if (char_ok && !lane_end) begin
                fwd_valid        <= 1'b1;
                fwd_thread.pc    <= thr.pc + 1'b1;
                fwd_thread.cc_id <= thr.cc_id + 1'b1;
                state            <= cs_emit;
              end
            end
            op_jmp: begin
              loc_valid  <= 1'b1;
              loc_thread <= '{pc: instr.target, cc_id: thr.cc_id};
              state      <= cs_emit;
            end
            op_split: begin
              loc_valid     <= 1'b1;
              loc_thread.pc <= thr.pc + 1'b1;
              loc_thread.cc_id <= thr.cc_id;
              state         <= cs_split;
            end
            op_accept: accept_hit <= lane_end;
            default: ;
          endcase
        end
        // instr still holds the split word, pc is unchanged
        cs_split: begin
          if (loc_ready) begin
            loc_thread.pc <= instr.target;
            state         <= cs_emit;
          end
        end
        cs_emit: begin
          if ((fwd_valid && fwd_ready) || (loc_valid && loc_ready)) begin
            fwd_valid <= 1'b0;
            loc_valid <= 1'b0;
            state     <= cs_idle;
          end
        end
        default: state <= cs_idle;
      endcase
    end
  end

endmodule

/* vector_engine.sv */
//**************************************************************************
// Ring of four lanes, each an arbiter, a thread FIFO and a regex core
//**************************************************************************
`timescale 1ns/1ps

module vector_engine #(
  parameter int fifo_depth_bits = 3
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 flush,
  input  regex_pkg::window_t                                   window,
  input  logic                                                 in_valid,
  input  regex_pkg::thread_t                                   in_thread,
  output logic                                                 in_ready,
  output logic                                                 out_valid,
  output regex_pkg::thread_t                                   out_thread,
  input  logic                                                 out_ready,
  output logic [regex_pkg::lanes-1:0][regex_pkg::pc_width-1:0] fetch_pc,
  input  regex_pkg::instr_t [regex_pkg::lanes-1:0]             instr,
  output logic                                                 accept_hit,
  output logic [regex_pkg::lanes-1:0]                          lane_live
);
  import regex_pkg::*;

  logic    [lanes-1:0] in0_valid, in0_ready;
  thread_t [lanes-1:0] in0_thread;
  logic    [lanes-1:0] arb_valid, fifo_full, fifo_empty, pop;
  thread_t [lanes-1:0] arb_thread, fifo_dout;
  logic    [lanes-1:0] fwd_valid, fwd_ready, loc_valid, loc_ready;
  thread_t [lanes-1:0] fwd_thread, loc_thread;
  logic    [lanes-1:0] hit, busy;

  // Lane 0 takes outside threads, the last core drives the output port
  assign in_ready   = in0_ready[0];
  assign out_valid  = fwd_valid[lanes-1];
  assign out_thread = fwd_thread[lanes-1];
  assign accept_hit = |hit;
  assign lane_live  = ~fifo_empty | busy;

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    if (i == 0) begin : g_head
      assign in0_valid[i]  = in_valid;
      assign in0_thread[i] = in_thread;
    end else begin : g_link
      assign in0_valid[i]  = fwd_valid[i-1];
      assign in0_thread[i] = fwd_thread[i-1];
    end

    if (i == lanes - 1) begin : g_tail
      assign fwd_ready[i] = out_ready;
    end else begin : g_next
      assign fwd_ready[i] = in0_ready[i+1];
    end

    thread_arbiter u_arb (
      .clk(clk), .rst_n(rst_n),
      .in0_valid(in0_valid[i]), .in0_thread(in0_thread[i]), .in0_ready(in0_ready[i]),
      .in1_valid(loc_valid[i]), .in1_thread(loc_thread[i]), .in1_ready(loc_ready[i]),
      .out_valid(arb_valid[i]), .out_thread(arb_thread[i]), .out_ready(!fifo_full[i])
    );

    thread_fifo #(.fifo_depth_bits(fifo_depth_bits)) u_fifo (
      .clk(clk), .rst_n(rst_n), .flush(flush),
      .push(arb_valid[i]), .din(arb_thread[i]), .full(fifo_full[i]),
      .pop(pop[i]), .dout(fifo_dout[i]), .empty(fifo_empty[i])
    );

    regex_core u_core (
      .clk(clk), .rst_n(rst_n), .flush(flush),
      .lane_char(window.chars[i]), .lane_enable(window.enable[i]),
      .lane_end(window.end_of_s[i]),
      .fifo_thread(fifo_dout[i]), .fifo_empty(fifo_empty[i]), .pop(pop[i]),
      .fetch_pc(fetch_pc[i]), .instr(instr[i]),
      .fwd_valid(fwd_valid[i]), .fwd_thread(fwd_thread[i]), .fwd_ready(fwd_ready[i]),
      .loc_valid(loc_valid[i]), .loc_thread(loc_thread[i]), .loc_ready(loc_ready[i]),
      .accept_hit(hit[i]), .busy(busy[i])
    );
  end

endmodule

/* engine_control.sv */
//**************************************************************************
// Run control FSM with quiet detection, timeout flush and sticky accept
//**************************************************************************
`timescale 1ns/1ps

module engine_control (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [regex_pkg::lanes-1:0] lane_live,
  input  logic                        pending,
  input  logic                        accept_hit,
  input  logic                        timeout,
  output logic                        running,
  output logic                        done,
  output logic                        accepted,
  output logic                        flush
);
  import regex_pkg::*;

  run_state_e state;
  logic       quiet_now;
  logic       quiet_q;

  assign quiet_now = (lane_live == '0) && !pending;
  assign running   = (state == st_run);
  assign done      = (state == st_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      quiet_q  <= 1'b0;
      accepted <= 1'b0;
      flush    <= 1'b0;
    end else begin
      flush   <= 1'b0;
      quiet_q <= quiet_now && running;
      if (start) accepted <= 1'b0;
      else if (accept_hit) accepted <= 1'b1;
      case (state)
        st_idle: if (start) state <= st_run;
        st_run: begin
          // Budget exhausted, empty every lane during the done cycle
          if (timeout) begin
            state <= st_done;
            flush <= 1'b1;
          end else if (quiet_now && quiet_q) begin
            state <= st_done;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* run_timer.sv */
//**************************************************************************
// Run cycle counter with cycle budget timeout
//**************************************************************************
`timescale 1ns/1ps

module run_timer #(
  parameter int max_run_cycles = 200
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  start,
  input  logic                                  running,
  output logic                                  timeout,
  output logic [$clog2(max_run_cycles+1)-1:0]   run_cycles
);

  // Count saturates at the budget and holds until the next start
  assign timeout = (run_cycles == max_run_cycles);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_cycles <= '0;
    end else if (start) begin
      run_cycles <= '0;
    end else if (running && !timeout) begin
      run_cycles <= run_cycles + 1'b1;
    end
  end

endmodule

/* regex_engine_top.sv */
//**************************************************************************
// Regex engine top: program memory, lane ring, run control and run timer
//**************************************************************************
`timescale 1ns/1ps

module regex_engine_top #(
  parameter int fifo_depth_bits = 3,
  parameter int max_run_cycles  = 200
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                prog_wr,
  input  logic [regex_pkg::pc_width-1:0]      prog_addr,
  input  regex_pkg::instr_t                   prog_instr,
  input  regex_pkg::window_t                  window,
  input  logic                                in_valid,
  input  regex_pkg::thread_t                  in_thread,
  output logic                                in_ready,
  output logic                                out_valid,
  output regex_pkg::thread_t                  out_thread,
  input  logic                                out_ready,
  output logic                                running,
  output logic                                done,
  output logic                                accepted,
  output logic                                timeout,
  output logic [$clog2(max_run_cycles+1)-1:0] run_cycles
);
  import regex_pkg::*;

  logic   [lanes-1:0][pc_width-1:0] fetch_pc;
  instr_t [lanes-1:0]               instr;
  logic   [lanes-1:0]               lane_live;
  logic                             accept_hit;
  logic                             flush;
  logic                             start;
  logic                             pending;

  // First thread transfer of a run starts it
  assign start   = in_valid && in_ready && !running;
  assign pending = in_valid || out_valid;

  instr_mem u_mem (
    .clk(clk), .wr_en(prog_wr), .wr_addr(prog_addr), .wr_instr(prog_instr),
    .rd_pc(fetch_pc), .rd_instr(instr)
  );

  vector_engine #(.fifo_depth_bits(fifo_depth_bits)) u_engine (
    .clk(clk), .rst_n(rst_n), .flush(flush), .window(window),
    .in_valid(in_valid), .in_thread(in_thread), .in_ready(in_ready),
    .out_valid(out_valid), .out_thread(out_thread), .out_ready(out_ready),
    .fetch_pc(fetch_pc), .instr(instr),
    .accept_hit(accept_hit), .lane_live(lane_live)
  );

  engine_control u_ctrl (
    .clk(clk), .rst_n(rst_n), .start(start), .lane_live(lane_live),
    .pending(pending), .accept_hit(accept_hit), .timeout(timeout),
    .running(running), .done(done), .accepted(accepted), .flush(flush)
  );

  run_timer #(.max_run_cycles(max_run_cycles)) u_timer (
    .clk(clk), .rst_n(rst_n), .start(start), .running(running),
    .timeout(timeout), .run_cycles(run_cycles)
  );

endmodule

/* regex_engine_asserts.sv */
//**************************************************************************
// Regex engine checks on thread handshakes and run control outputs
//**************************************************************************
`timescale 1ns/1ps

module regex_engine_asserts (
  input logic               clk,
  input logic               rst_n,
  input logic               in_valid,
  input logic               in_ready,
  input regex_pkg::thread_t in_thread,
  input logic               out_valid,
  input logic               out_ready,
  input regex_pkg::thread_t out_thread,
  input logic               running,
  input logic               done,
  input logic               timeout,
  input logic               flush
);

  // Read by the testbench for its closing summary
  int fail_count = 0;

  a_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable(in_thread))
    else begin
      $error("input thread changed while waiting for ready");
      fail_count++;
    end

  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_thread))
    else begin
      $error("output thread changed while waiting for ready");
      fail_count++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      $error("done held for more than one cycle");
      fail_count++;
    end

  a_flush_timeout: assert property (@(posedge clk) disable iff (!rst_n) flush |-> timeout)
    else begin
      $error("flush raised without a timeout");
      fail_count++;
    end

  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !running)
    else begin
      $error("engine running right after reset");
      fail_count++;
    end

endmodule

bind regex_engine_top regex_engine_asserts u_asserts (
  .clk(clk), .rst_n(rst_n),
  .in_valid(in_valid), .in_ready(in_ready), .in_thread(in_thread),
  .out_valid(out_valid), .out_ready(out_ready), .out_thread(out_thread),
  .running(running), .done(done), .timeout(timeout), .flush(flush)
);

/* tb_regex_engine.sv */
//**************************************************************************
// Regex engine testbench: literal, alternation, any, spin and lane stall
//**************************************************************************
`timescale 1ns/1ps

module tb_regex_engine;
  import regex_pkg::*;

  localparam int fifo_depth_bits = 3;
  localparam int max_run_cycles  = 200;
  // Eight runs against the run budget, plus margin
  localparam int cycle_limit     = 2000;

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                prog_wr;
  logic [pc_width-1:0]                 prog_addr;
  instr_t                              prog_instr;
  window_t                             window;
  logic                                in_valid;
  thread_t                             in_thread;
  logic                                in_ready;
  logic                                out_valid;
  thread_t                             out_thread;
  logic                                out_ready;
  logic                                running;
  logic                                done;
  logic                                accepted;
  logic                                timeout;
  logic [$clog2(max_run_cycles+1)-1:0] run_cycles;
  int                                  errors = 0;
  int                                  cycles = 0;

  regex_engine_top #(
    .fifo_depth_bits(fifo_depth_bits), .max_run_cycles(max_run_cycles)
  ) u_dut (
    .clk(clk), .rst_n(rst_n),
    .prog_wr(prog_wr), .prog_addr(prog_addr), .prog_instr(prog_instr),
    .window(window), .in_valid(in_valid), .in_thread(in_thread), .in_ready(in_ready),
    .out_valid(out_valid), .out_thread(out_thread), .out_ready(out_ready),
    .running(running), .done(done), .accepted(accepted), .timeout(timeout),
    .run_cycles(run_cycles)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout: no result after %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // All drive tasks start and end 1 ns after a rising edge
  task automatic write_word(input logic [pc_width-1:0] addr, input opcode_e op,
                            input logic [char_width-1:0] ch, input logic [pc_width-1:0] tgt);
    prog_wr    = 1'b1;
    prog_addr  = addr;
    prog_instr = '{opcode: op, ch: ch, target: tgt};
    @(posedge clk);
    #1 prog_wr = 1'b0;
  endtask

  task automatic load_program(input string which);
    case (which)
      "abc": begin
        write_word(0, op_match, "a", 0);
        write_word(1, op_match, "b", 0);
        write_word(2, op_match, "c", 0);
        write_word(3, op_accept, 0, 0);
      end
      // a(b|c) with the b branch jumping over the c branch
      "alt": begin
        write_word(0, op_match, "a", 0);
        write_word(1, op_split, 0, 4);
        write_word(2, op_match, "b", 0);
        write_word(3, op_jmp, 0, 5);
        write_word(4, op_match, "c", 0);
        write_word(5, op_accept, 0, 0);
      end
      "any4": for (int i = 0; i < 4; i++) write_word(6'(i), op_any, 0, 0);
      default: write_word(0, op_jmp, 0, 0);
    endcase
  endtask

  function automatic window_t make_window(input string s, input logic [3:0] en,
                                          input logic [3:0] eos);
    window_t w;
    w = '0;
    for (int i = 0; i < s.len() && i < lanes; i++) w.chars[i] = s[i];
    w.enable   = en;
    w.end_of_s = eos;
    return w;
  endfunction

  task automatic inject_thread();
    in_valid  = 1'b1;
    in_thread = '{pc: '0, cc_id: '0};
    do @(negedge clk); while (!in_ready);
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  task automatic wait_done();
    do @(negedge clk); while (!done);
  endtask

  // Wait for the done pulse of the current run and check its result
  task automatic finish_run(input string name, input logic exp_acc);
    wait_done();
    check_value({name, " accepted"}, exp_acc, accepted);
    check_value({name, " timeout"}, 0, timeout);
    @(posedge clk);
    #1;
  endtask

  task automatic run_window(input string name, input window_t w, input logic exp_acc);
    window = w;
    inject_thread();
    finish_run(name, exp_acc);
  endtask

  initial begin
    rst_n      = 1'b0;
    prog_wr    = 1'b0;
    prog_addr  = '0;
    prog_instr = '0;
    window     = '0;
    in_valid   = 1'b0;
    in_thread  = '0;
    out_ready  = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    load_program("abc");
    run_window("abc", make_window("abc", 4'hf, 4'b1000), 1'b1);
    run_window("abd", make_window("abd", 4'hf, 4'b1000), 1'b0);

    load_program("alt");
    run_window("alt ab", make_window("ab", 4'hf, 4'b0100), 1'b1);
    run_window("alt ac", make_window("ac", 4'hf, 4'b0100), 1'b1);
    run_window("alt ad", make_window("ad", 4'hf, 4'b0100), 1'b0);

    // Thread leaves lane 3 and waits on a stalled output port
    load_program("any4");
    out_ready = 1'b0;
    window    = make_window("wxyz", 4'hf, 4'h0);
    inject_thread();
    do @(negedge clk); while (!out_valid);
    check_value("any4 out_thread", {6'd4, 2'd0}, out_thread);
    repeat (10) begin
      @(negedge clk);
      check_value("any4 held done", 0, done);
      check_value("any4 held out_thread", {6'd4, 2'd0}, out_thread);
    end
    @(posedge clk);
    #1 out_ready = 1'b1;
    finish_run("any4", 1'b0);

    // Lane 0 held off until its FIFO fills and the next thread waits on ready
    load_program("spin");
    window = make_window("abc", 4'b1110, 4'b1000);
    repeat (2**fifo_depth_bits) inject_thread();
    in_valid = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_value("spin in_ready", 0, in_ready);
    end
    @(posedge clk);
    #1 window.enable[0] = 1'b1;
    inject_thread();
    // Endless jump loop runs into the cycle budget
    wait_done();
    check_value("spin accepted", 0, accepted);
    check_value("spin timeout", 1, timeout);
    check_value("spin run_cycles", max_run_cycles, run_cycles);
    @(posedge clk);
    #1;

    // Lane 1 stalls the run until its enable returns
    load_program("abc");
    window = make_window("abc", 4'b1101, 4'b1000);
    inject_thread();
    repeat (20) begin
      @(negedge clk);
      check_value("stall done", 0, done);
      check_value("stall running", 1, running);
    end
    @(posedge clk);
    #1 window.enable[1] = 1'b1;
    finish_run("stall abc", 1'b1);

    $display("errors: %0d checks, %0d assertions", errors, u_dut.u_asserts.fail_count);
    if (errors == 0 && u_dut.u_asserts.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* files.f */
regex_pkg.sv
instr_mem.sv
thread_fifo.sv
thread_arbiter.sv
regex_core.sv
vector_engine.sv
engine_control.sv
run_timer.sv
regex_engine_top.sv
regex_engine_asserts.sv
tb_regex_engine.sv
